/* Makefile */
TB_TOP = biss_master_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f biss_master.f --top-module biss_master

sim:
	verilator --binary --timing --assert -f biss_master.f --top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP)

clean:
	rm -rf obj_dir

/* biss_master.f */
+incdir+include
design/biss_pkg.sv
design/biss_wb_regs.sv
design/biss_channel.sv
design/biss_collector.sv
design/biss_master.sv
testbench/biss_encoder_model.sv
testbench/biss_master_tb.sv

/* design/biss_channel.sv */
`timescale 1ns/100ps
`include "biss_cfg.svh"

module biss_channel (
	input  logic                   clk,
	input  logic                   arst_n,
	input  biss_pkg::chan_cfg_t    cfg,
	input  logic                   start,
	output logic                   busy,
	output logic                   ma,
	input  logic                   slo,
	output logic                   done,
	output biss_pkg::chan_result_t result,
	input  logic                   take
);
	import biss_pkg::*;

	chan_state_t state;
	chan_cfg_t   cfg_q;        // Frame setup held for the whole frame
	div_t        cnt;
	bitcnt_t     bits_left;
	pos_t        shift;
	logic        accept;
	logic        ma_rise;

	// A pending result blocks new frames
	assign accept  = (state == ST_IDLE) && start && !done;
	assign ma_rise = (state == ST_CLK_LOW) && (cnt == '0);

	assign busy        = (state != ST_IDLE) || done;
	assign result.data = shift;
	assign result.bits = cfg_q.bits;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ST_IDLE;
			ma        <= 1'b1;       // MA idles high
			cnt       <= '0;
			bits_left <= '0;
			done      <= 1'b0;
		end else begin
			if (take)
				done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						bits_left <= cfg.bits;
						if (cfg.bits != '0) begin
							state <= ST_CLK_LOW;
							ma    <= 1'b0;
							cnt   <= cfg.divider - 1'b1;
						end else begin
							state <= ST_CDM;    // Empty frame goes straight to CDM
							ma    <= cfg.cdm;
							cnt   <= cfg.timeout - 1'b1;
						end
					end
				end
				ST_CLK_LOW: begin
					if (cnt == '0) begin
						state     <= ST_CLK_HIGH;
						ma        <= 1'b1;
						cnt       <= cfg_q.divider - 1'b1;
						bits_left <= bits_left - 1'b1;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				ST_CLK_HIGH: begin
					if (cnt != '0) begin
						cnt <= cnt - 1'b1;
					end else if (bits_left == '0) begin
						state <= ST_CDM;
						ma    <= cfg_q.cdm;
						cnt   <= cfg_q.timeout - 1'b1;
					end else begin
						state <= ST_CLK_LOW;
						ma    <= 1'b0;
						cnt   <= cfg_q.divider - 1'b1;
					end
				end
				ST_CDM: begin
					if (cnt == '0) begin
						state <= ST_RECOVER;
						ma    <= 1'b1;
						cnt   <= cfg_q.divider - 1'b1;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				ST_RECOVER: begin
					if (cnt == '0) begin
						state <= ST_IDLE;
						done  <= 1'b1;          // Held until the collector takes it
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Frame payload
	always_ff @(posedge clk) begin
		if (accept) begin
			cfg_q <= cfg;
			shift <= '0;
		end else if (ma_rise) begin
			shift <= {shift[`BISS_MAX_BITS-2:0], slo};   // MSB first
		end
	end

	a_ma_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
		(state == ST_IDLE) |-> ma);

	a_take_when_done: assert property (@(posedge clk) disable iff (!arst_n)
		take |-> done);

endmodule

/* design/biss_collector.sv */
`timescale 1ns/100ps
`include "biss_cfg.svh"

module biss_collector (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [`BISS_NCH-1:0]   done,
	input  biss_pkg::chan_result_t results [`BISS_NCH],
	output logic [`BISS_NCH-1:0]   take,
	output biss_pkg::fifo_entry_t  fifo_head,
	output logic                   fifo_nempty,
	input  logic                   fifo_pop
);
	import biss_pkg::*;

	localparam int NCH   = `BISS_NCH;
	localparam int DEPTH = `BISS_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	fifo_entry_t      mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	chan_t            rr_ptr;     // First channel to look at
	chan_t            grant;
	logic             grant_vld;
	logic             full;
	logic             push;

	// Search starts at the round-robin pointer
	always_comb begin
		int idx;
		grant_vld = 1'b0;
		grant     = '0;
		for (int i = 0; i < NCH; i++) begin
			idx = (int'(rr_ptr) + i) % NCH;
			if (!grant_vld && done[idx]) begin
				grant_vld = 1'b1;
				grant     = chan_t'(idx);
			end
		end
	end

	assign full        = count == CNT_W'(DEPTH);
	assign push        = grant_vld && !full;     // Full FIFO leaves done waiting
	assign take        = push ? (NCH'(1) << grant) : '0;
	assign fifo_nempty = count != '0;
	assign fifo_head   = mem[rd_ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			rr_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
				rr_ptr <= (grant == chan_t'(NCH - 1)) ? '0 : grant + 1'b1;
			end
			if (fifo_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, fifo_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr].chan   <= grant;
			mem[wr_ptr].result <= results[grant];
		end
	end

	a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		fifo_pop |-> fifo_nempty);

	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		count <= CNT_W'(DEPTH));

endmodule

/* design/biss_master.sv */
`timescale 1ns/100ps
`include "biss_cfg.svh"

module biss_master (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [7:0]           wb_adr,
	input  logic [31:0]          wb_dat_w,
	output logic [31:0]          wb_dat_r,
	output logic                 wb_ack,
	output logic [`BISS_NCH-1:0] ma,
	input  logic [`BISS_NCH-1:0] slo
);
	import biss_pkg::*;

	chan_cfg_t             cfg [`BISS_NCH];
	chan_result_t          results [`BISS_NCH];
	logic [`BISS_NCH-1:0]  start;
	logic [`BISS_NCH-1:0]  busy;
	logic [`BISS_NCH-1:0]  done;
	logic [`BISS_NCH-1:0]  take;
	fifo_entry_t           fifo_head;
	logic                  fifo_nempty;
	logic                  fifo_pop;

	biss_wb_regs i_regs (
		.clk, .arst_n,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.cfg, .start, .busy,
		.fifo_head, .fifo_nempty, .fifo_pop
	);

	for (genvar i = 0; i < `BISS_NCH; i++) begin : g_chan
		biss_channel i_chan (
			.clk, .arst_n,
			.cfg(cfg[i]), .start(start[i]), .busy(busy[i]),
			.ma(ma[i]), .slo(slo[i]),
			.done(done[i]), .result(results[i]), .take(take[i])
		);
	end

	biss_collector i_collect (
		.clk, .arst_n,
		.done, .results, .take,
		.fifo_head, .fifo_nempty, .fifo_pop
	);

endmodule

/* design/biss_pkg.sv */
`include "biss_cfg.svh"

package biss_pkg;

	typedef logic [`BISS_DIV_W-1:0] div_t;                      // Clocks per MA half period
	typedef logic [$clog2(`BISS_MAX_BITS + 1)-1:0] bitcnt_t;    // 0 to 64 bits
	typedef logic [`BISS_MAX_BITS-1:0] pos_t;
	typedef logic [$clog2(`BISS_NCH)-1:0] chan_t;

	// Per-channel setup written over the bus
	typedef struct packed {
		div_t    divider;
		div_t    timeout;
		bitcnt_t bits;
		logic    cdm;
	} chan_cfg_t;

	typedef struct packed {
		pos_t    data;     // Last bit received in bit 0
		bitcnt_t bits;
	} chan_result_t;

	// Result tagged with its source channel
	typedef struct packed {
		chan_t        chan;
		chan_result_t result;
	} fifo_entry_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CLK_LOW,
		ST_CLK_HIGH,
		ST_CDM,        // MA carries the CDM bit for the timeout
		ST_RECOVER
	} chan_state_t;

endpackage

/* design/biss_wb_regs.sv */
`timescale 1ns/100ps
`include "biss_cfg.svh"

module biss_wb_regs (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [7:0]               wb_adr,
	input  logic [31:0]              wb_dat_w,
	output logic [31:0]              wb_dat_r,
	output logic                     wb_ack,
	output biss_pkg::chan_cfg_t      cfg [`BISS_NCH],
	output logic [`BISS_NCH-1:0]     start,
	input  logic [`BISS_NCH-1:0]     busy,
	input  biss_pkg::fifo_entry_t    fifo_head,
	input  logic                     fifo_nempty,
	output logic                     fifo_pop
);
	import biss_pkg::*;

	localparam int NCH = `BISS_NCH;

	localparam logic [7:0] ADR_STATUS  = 8'h40;
	localparam logic [7:0] ADR_DATA_LO = 8'h44;
	localparam logic [7:0] ADR_DATA_HI = 8'h48;
	localparam logic [7:0] ADR_BITS    = 8'h4C;

	localparam logic [3:0] OFS_DIV     = 4'h0;
	localparam logic [3:0] OFS_TIMEOUT = 4'h4;
	localparam logic [3:0] OFS_FRAME   = 4'h8;

	logic        req;
	logic        is_chan;
	chan_t       sel_chan;
	logic [31:0] rd_word;

	// New cycle seen, ack not yet given
	assign req      = wb_cyc && wb_stb && !wb_ack;
	assign is_chan  = wb_adr[7:4] < 4'(NCH);     // Per-channel blocks at c*16
	assign sel_chan = wb_adr[4 +: $bits(chan_t)];

	// Head is popped on the edge that captures its high word
	assign fifo_pop = req && !wb_we && (wb_adr == ADR_DATA_HI) && fifo_nempty;

	always_comb begin
		rd_word = '0;
		if (is_chan) begin
			case (wb_adr[3:0])
				OFS_DIV:     rd_word[`BISS_DIV_W-1:0] = cfg[sel_chan].divider;
				OFS_TIMEOUT: rd_word[`BISS_DIV_W-1:0] = cfg[sel_chan].timeout;
				OFS_FRAME:   rd_word[7:0] = {cfg[sel_chan].cdm, cfg[sel_chan].bits};
				default:     rd_word = '0;
			endcase
		end else begin
			case (wb_adr)
				ADR_STATUS: begin
					rd_word[NCH-1:0] = busy;
					rd_word[8]       = fifo_nempty;
					if (fifo_nempty)
						rd_word[9 +: $bits(chan_t)] = fifo_head.chan;
				end
				ADR_DATA_LO: rd_word = fifo_head.result.data[31:0];
				ADR_DATA_HI: rd_word = fifo_head.result.data[63:32];
				ADR_BITS:    rd_word[$bits(bitcnt_t)-1:0] = fifo_head.result.bits;
				default:     rd_word = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack <= 1'b0;
			start  <= '0;
			for (int c = 0; c < NCH; c++) begin
				cfg[c] <= '{divider: div_t'(1), timeout: div_t'(1), bits: '0, cdm: 1'b0};
			end
		end else begin
			wb_ack <= req;
			start  <= '0;         // Single cycle pulse
			if (req && wb_we && is_chan) begin
				case (wb_adr[3:0])
					OFS_DIV:     cfg[sel_chan].divider <= wb_dat_w[`BISS_DIV_W-1:0];
					OFS_TIMEOUT: cfg[sel_chan].timeout <= wb_dat_w[`BISS_DIV_W-1:0];
					OFS_FRAME: begin
						cfg[sel_chan].bits <= wb_dat_w[6:0];
						cfg[sel_chan].cdm  <= wb_dat_w[7];
						start[sel_chan]    <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// Read data lands with the ack
	always_ff @(posedge clk) begin
		if (req)
			wb_dat_r <= rd_word;
	end

	a_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
		wb_ack |=> !wb_ack);

endmodule

/* include/biss_cfg.svh */
`ifndef BISS_CFG_SVH
`define BISS_CFG_SVH

// Number of encoder channels
`define BISS_NCH 4

// Longest SLO frame in bits
`define BISS_MAX_BITS 64

// Divider and timeout counter width
`define BISS_DIV_W 16

// Result FIFO entries
`define BISS_FIFO_DEPTH 4

`endif

/* testbench/biss_encoder_model.sv */
`timescale 1ns/100ps
`include "biss_cfg.svh"

module biss_encoder_model (
	input  logic              ma,
	input  logic              load,
	input  biss_pkg::pos_t    value,
	input  biss_pkg::bitcnt_t bits,
	output logic              slo
);
	import biss_pkg::*;

	int   idx = 0;        // Bits still to send
	logic slo_q = 1'b0;

	assign slo = slo_q;

	// Load arms a new word; each falling MA edge puts out the next bit
	always @(posedge load or negedge ma) begin
		if (load) begin
			idx = int'(bits);
		end else if (idx > 0) begin
			idx   = idx - 1;
			slo_q = value[idx];   // MSB first
		end else begin
			slo_q = 1'b0;         // Nothing left, e.g. during CDM
		end
	end

endmodule

/* testbench/biss_input.txt */
# test channel divider timeout bits cdm value(hex); test 1 single, 2 same time,
# 3 start while busy, 4 FIFO full. Words from $random, seed 32'h630e2c65
1 0 2 5 24 1 9c3f5a17e2b4c068
1 1 1 3 64 0 d1e8a47305bf9c2e
1 2 3 4 13 1 4a7b0c9e13f6d852
1 3 4 2 32 0 e05d27b8c4196af3
2 0 1 2 17 0 7f21c6e3a95b0d48
2 1 2 1 40 1 31a9e4d07c6b2f85
2 2 1 3 64 0 b86f0d2157e3ac94
2 3 3 2 9 1 05c7e9b3d2a84f61
3 1 2 3 20 0 c24e7a91f0365bd8
3 1 1 1 8 1 6d93b15e08f2c7a4
4 0 1 2 12 1 a3f0581cd7e69b22
4 1 2 1 30 0 1e6c9da4b3087f5f
4 2 1 4 48 1 f7428be05c1da936
4 3 2 2 16 0 8b15f3e96a40d2c7
4 2 1 2 25 1 57de0a3c914bf86e

/* testbench/biss_master_tb.sv */
`timescale 1ns/100ps
`include "biss_cfg.svh"

module biss_master_tb;
	import biss_pkg::*;

	localparam int NCH        = `BISS_NCH;
	localparam int MAX_REQ    = 32;
	localparam int ACK_LIMIT  = 20;
	localparam int WAIT_LIMIT = 5000;

	logic           clk;
	logic           arst_n;
	logic           wb_cyc;
	logic           wb_stb;
	logic           wb_we;
	logic [7:0]     wb_adr;
	logic [31:0]    wb_dat_w;
	logic [31:0]    wb_dat_r;
	logic           wb_ack;
	logic [NCH-1:0] ma;
	logic [NCH-1:0] slo;
	logic [NCH-1:0] enc_load;
	pos_t           enc_value [NCH];
	bitcnt_t        enc_bits [NCH];

	// Frame requests from the data file
	int      req_test [MAX_REQ];
	chan_t   req_ch [MAX_REQ];
	div_t    req_div [MAX_REQ];
	div_t    req_tmo [MAX_REQ];
	bitcnt_t req_bits [MAX_REQ];
	logic    req_cdm [MAX_REQ];
	pos_t    req_val [MAX_REQ];
	int      nreq;

	biss_master i_dut (
		.clk, .arst_n,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.ma, .slo
	);

	for (genvar i = 0; i < NCH; i++) begin : g_enc
		biss_encoder_model i_enc (
			.ma(ma[i]), .load(enc_load[i]), .value(enc_value[i]),
			.bits(enc_bits[i]), .slo(slo[i])
		);
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic stop_with_failure();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_pos(input string name, input pos_t got, input pos_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_bitcnt(input string name, input bitcnt_t got, input bitcnt_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_chan(input string name, input chan_t got, input chan_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// Low n bits of the encoder word, as they arrive MSB first
	function automatic pos_t low_bits(input pos_t v, input bitcnt_t n);
		return v & ~({`BISS_MAX_BITS{1'b1}} << n);
	endfunction

	function automatic logic [7:0] chan_addr(input chan_t ch, input int ofs);
		return 8'(int'(ch) * 16 + ofs);
	endfunction

	task automatic wait_ack(input logic [7:0] adr);
		int n;
		n = 0;
		next_cycle();
		while (!wb_ack) begin
			n++;
			if (n > ACK_LIMIT) begin
				$display("Timeout: no wb_ack for address 0x%h", adr);
				stop_with_failure();
			end
			next_cycle();
		end
	endtask

	task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = dat;
		wait_ack(adr);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		wait_ack(adr);
		dat    = wb_dat_r;       // Valid together with the ack
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// Poll status until the masked bits match
	task automatic wait_status(input logic [31:0] mask, input logic [31:0] want,
			input string what);
		logic [31:0] st;
		int          n;
		n = 0;
		wb_read(8'h40, st);
		while ((st & mask) != want) begin
			n++;
			if (n > WAIT_LIMIT) begin
				$display("Timeout: status never showed %s", what);
				stop_with_failure();
			end
			wb_read(8'h40, st);
		end
	endtask

	task automatic wait_ma(input int ch, input logic level, input string what);
		int n;
		n = 0;
		while (ma[ch] !== level) begin
			n++;
			if (n > WAIT_LIMIT) begin
				$display("Timeout: MA of channel %0d stuck while waiting for %s", ch, what);
				stop_with_failure();
			end
			next_cycle();
		end
	endtask

	task automatic read_requests();
		int    fd;
		int    n;
		int    t, ch, dv, tm, nb, cd;
		pos_t  val;
		string line;
		fd = $fopen("testbench/biss_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/biss_input.txt");
			stop_with_failure();
		end
		nreq = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%d %d %d %d %d %d %h", t, ch, dv, tm, nb, cd, val);
				if (n == 7 && nreq < MAX_REQ) begin
					req_test[nreq] = t;
					req_ch[nreq]   = chan_t'(ch);
					req_div[nreq]  = div_t'(dv);
					req_tmo[nreq]  = div_t'(tm);
					req_bits[nreq] = bitcnt_t'(nb);
					req_cdm[nreq]  = cd[0];
					req_val[nreq]  = val;
					nreq++;
				end
			end
		end
		$fclose(fd);
	endtask

	// Divider and timeout with readback, then arm the encoder model
	task automatic setup_line(input int k);
		logic [31:0] rd;
		wb_write(chan_addr(req_ch[k], 0), 32'(req_div[k]));
		wb_write(chan_addr(req_ch[k], 4), 32'(req_tmo[k]));
		wb_read(chan_addr(req_ch[k], 0), rd);
		check_word("divider readback", rd, 32'(req_div[k]));
		wb_read(chan_addr(req_ch[k], 4), rd);
		check_word("timeout readback", rd, 32'(req_tmo[k]));
		enc_value[req_ch[k]] = req_val[k];
		enc_bits[req_ch[k]]  = req_bits[k];
		next_cycle();
		enc_load[req_ch[k]] = 1'b1;
		next_cycle();
		enc_load[req_ch[k]] = 1'b0;
	endtask

	task automatic start_line(input int k);
		wb_write(chan_addr(req_ch[k], 8), {24'h0, req_cdm[k], req_bits[k]});
	endtask

	task automatic watch_frame(input int k);
		int ch;
		int low_cnt;
		ch = int'(req_ch[k]);
		wait_ma(ch, 1'b0, "the first MA falling edge");
		low_cnt = 0;
		while (ma[ch] == 1'b0 && low_cnt <= int'(req_div[k])) begin
			low_cnt++;
			next_cycle();
		end
		check_word("ma low cycles", 32'(low_cnt), 32'(req_div[k]));
		for (int b = 1; b < int'(req_bits[k]); b++) begin
			wait_ma(ch, 1'b0, "a MA falling edge");
			wait_ma(ch, 1'b1, "a MA rising edge");
		end
		repeat (int'(req_div[k])) next_cycle();     // High half of the last bit
		check_word("ma during cdm", 32'(ma[ch]), 32'(req_cdm[k]));
		repeat (int'(req_tmo[k]) + int'(req_div[k])) next_cycle();
		check_word("ma after done", 32'(ma[ch]), 32'h1);
	endtask

	task automatic pop_entry(output chan_t ch, output pos_t data, output bitcnt_t nb);
		logic [31:0] st, lo, hi, bw;
		wb_read(8'h40, st);
		wb_read(8'h44, lo);
		wb_read(8'h4C, bw);
		wb_read(8'h48, hi);          // Pops the head
		ch   = st[9 +: $bits(chan_t)];
		data = {hi, lo};
		nb   = bw[$bits(bitcnt_t)-1:0];
	endtask

	// Pop n entries and match each to the oldest open request of its channel.
	// An entry whose channel has no open request is held against the oldest one left
	task automatic collect_group(input int first, input int n);
		bit          used [MAX_REQ];
		chan_t       ch;
		pos_t        data;
		bitcnt_t     nb;
		int          hit;
		logic [31:0] st;
		for (int e = 0; e < n; e++) begin
			wait_status(32'h100, 32'h100, "a FIFO entry");
			pop_entry(ch, data, nb);
			hit = -1;
			for (int k = first; k < first + n; k++) begin
				if (hit < 0 && !used[k] && req_ch[k] == ch)
					hit = k;
			end
			for (int k = first; k < first + n; k++) begin
				if (hit < 0 && !used[k])
					hit = k;
			end
			used[hit] = 1'b1;
			check_chan("fifo channel", ch, req_ch[hit]);
			check_pos("fifo data", data, low_bits(req_val[hit], req_bits[hit]));
			check_bitcnt("fifo bit count", nb, req_bits[hit]);
		end
		wb_read(8'h40, st);
		check_word("status after drain", st, 32'h0);
	endtask

	task automatic run_single(input int k);
		logic [31:0] rd;
		setup_line(k);
		start_line(k);
		watch_frame(k);
		collect_group(k, 1);
		wb_read(chan_addr(req_ch[k], 8), rd);
		check_word("frame control readback", rd, {24'h0, req_cdm[k], req_bits[k]});
	endtask

	task automatic run_backpressure(input int first, input int n);
		int          last;
		int          frame_cycles;
		logic [31:0] st;
		last = first + n - 1;
		for (int k = first; k < last; k++)
			setup_line(k);
		for (int k = first; k < last; k++)
			start_line(k);
		wait_status(32'((1 << NCH) - 1), 32'h0, "all channels idle");
		setup_line(last);
		start_line(last);
		frame_cycles = 2 * int'(req_div[last]) * int'(req_bits[last])
			+ int'(req_tmo[last]) + int'(req_div[last]);
		repeat (frame_cycles + 4) next_cycle();
		wb_read(8'h40, st);
		check_word("busy with FIFO full", 32'(st[NCH-1:0]), 32'(1) << req_ch[last]);
		collect_group(first, n);
	endtask

	initial begin
		int          i;
		int          n;
		logic [31:0] rd;
		arst_n   = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		enc_load = '0;
		for (int c = 0; c < NCH; c++) begin
			enc_value[c] = '0;
			enc_bits[c]  = '0;
		end
		read_requests();
		if (nreq == 0) begin
			$display("The data file holds no frame requests");
			stop_with_failure();
		end
		repeat (10) @(posedge clk);
		#1 arst_n = 1'b1;
		next_cycle();
		wb_read(8'h40, rd);
		check_word("status after reset", rd, 32'h0);
		check_word("ma after reset", 32'(ma), 32'((1 << NCH) - 1));
		i = 0;
		while (i < nreq) begin
			n = 1;
			while (i + n < nreq && req_test[i + n] == req_test[i])
				n++;
			case (req_test[i])
				1: for (int k = i; k < i + n; k++) run_single(k);
				2: begin
					for (int k = i; k < i + n; k++)
						setup_line(k);
					for (int k = i; k < i + n; k++)
						start_line(k);
					collect_group(i, n);
				end
				3: begin
					setup_line(i);
					start_line(i);
					start_line(i + 1);        // Channel is busy, start dropped
					collect_group(i, 1);
				end
				4: run_backpressure(i, n);
				default: begin
					$display("Unknown test number %0d in the data file", req_test[i]);
					stop_with_failure();
				end
			endcase
			i += n;
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule
